// ==== rtl/usb_bulk_config.svh ====
`ifndef USB_BULK_CONFIG_SVH
`define USB_BULK_CONFIG_SVH

// Bytes in one full bulk chunk, kept small so that chunking shows up quickly
`define USB_MAX_PACKET_SIZE 8

// Packet FIFO size in bytes, must be a power of two
`define PACKET_FIFO_DEPTH 32

// Endpoint numbers answered by the two bulk IN endpoints
`define EP1_ADDR 4'd1
`define EP2_ADDR 4'd2

`endif

// ==== rtl/usb_bulk_pkg.sv ====
package usb_bulk_pkg;

  `include "usb_bulk_config.svh"

  // One payload byte on any stream
  typedef logic [7:0] byte_t;

  // Endpoint number carried by an IN token
  typedef logic [3:0] ep_addr_t;

  // Byte index within one chunk
  typedef logic [$clog2(`USB_MAX_PACKET_SIZE)-1:0] pkt_count_t;

  // FIFO fill level, one extra bit so that full is representable
  typedef logic [$clog2(`PACKET_FIFO_DEPTH):0] fifo_level_t;

  // Receive side of an endpoint
  typedef enum logic [1:0] {RX_HALT, RX_RECV, RX_FULL} rx_state_t;

  // Transmit side of an endpoint
  typedef enum logic [2:0] {TX_IDLE, TX_SEND, TX_WAIT, TX_NONE, TX_REDO} tx_state_t;

  // Token router and PID prefixing
  typedef enum logic [1:0] {MX_IDLE, MX_PID, MX_DATA, MX_WAIT} mux_state_t;

  // DATA PIDs with their check nibbles
  localparam byte_t PID_DATA0 = 8'hC3;
  localparam byte_t PID_DATA1 = 8'h4B;

endpackage

// ==== rtl/byte_stream_if.sv ====
`timescale 1ns/1ns

interface byte_stream_if
  import usb_bulk_pkg::*;
();

  logic  tvalid;
  logic  tready;
  // Low only on the single ZDP beat
  logic  tkeep;
  logic  tlast;
  byte_t tdata;

  // Producer of the bytes
  modport source (output tvalid, tkeep, tlast, tdata, input tready);

  // Consumer of the bytes
  modport sink (input tvalid, tkeep, tlast, tdata, output tready);

endinterface

// ==== rtl/packet_fifo.sv ====
`timescale 1ns/1ns

`include "usb_bulk_config.svh"

module packet_fifo
  import usb_bulk_pkg::*;
(
  input  logic        clock,
  input  logic        rst_i,

  // Chunk control from the endpoint
  input  logic        save_i,
  input  logic        redo_i,
  input  logic        next_i,

  // Write side
  input  logic        valid_i,
  output logic        ready_o,
  input  logic        last_i,
  input  byte_t       data_i,

  // Read side through the output register
  output logic        valid_o,
  input  logic        ready_i,
  output logic        last_o,
  output byte_t       data_o,

  output fifo_level_t level_o
);

  localparam int DEPTH = `PACKET_FIFO_DEPTH;
  localparam int AW = $clog2(DEPTH);

  // Storage, bytes plus their frame-end flags
  byte_t mem_data [DEPTH];
  logic  mem_last [DEPTH];

  // Pointers carry one wrap bit, same width as the level
  fifo_level_t wr_ptr;
  fifo_level_t cm_ptr;
  fifo_level_t rd_ptr;
  fifo_level_t st_ptr;

  logic wr_en;
  logic avail;
  logic load;

  // Level spans from the unreleased chunk start to the write pointer
  assign level_o = wr_ptr - st_ptr;
  assign ready_o = level_o != fifo_level_t'(DEPTH);
  assign wr_en = valid_i && ready_o;

  // Only committed bytes may be read
  assign avail = rd_ptr != cm_ptr;

  // Fill the output register when empty or being drained
  assign load = avail && (!valid_o || ready_i) && !redo_i;

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem_data[wr_ptr[AW-1:0]] <= data_i;
      mem_last[wr_ptr[AW-1:0]] <= last_i;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      data_o <= mem_data[rd_ptr[AW-1:0]];
      last_o <= mem_last[rd_ptr[AW-1:0]];
    end
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      wr_ptr <= '0;
      cm_ptr <= '0;
      rd_ptr <= '0;
      st_ptr <= '0;
      valid_o <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end

      // Commit includes a byte written on the same edge
      if (save_i) begin
        cm_ptr <= wr_ptr + fifo_level_t'(wr_en);
      end

      // Rewind to the chunk start and drop any prefetched byte
      if (redo_i) begin
        rd_ptr <= st_ptr;
        valid_o <= 1'b0;
      end else if (load) begin
        rd_ptr <= rd_ptr + 1'b1;
        valid_o <= 1'b1;
      end else if (ready_i) begin
        valid_o <= 1'b0;
      end

      // A byte held in the output register is not consumed yet
      // so the new chunk starts one behind the read pointer
      if (next_i) begin
        st_ptr <= rd_ptr - fifo_level_t'(valid_o);
      end
    end
  end

endmodule

// ==== rtl/ep_bulk_in.sv ====
`timescale 1ns/1ns

`include "usb_bulk_config.svh"

module ep_bulk_in
  import usb_bulk_pkg::*;
(
  input  logic clock,
  input  logic rst_i,

  // Configuration events from the control pipe
  input  logic set_conf_i,
  input  logic clr_conf_i,

  // Transaction signals routed by the multiplexer
  input  logic selected_i,
  input  logic ack_recv_i,
  input  logic timedout_i,

  output logic ep_ready_o,
  output logic stalled_o,
  output logic parity_o,

  // Bulk data source
  input  logic  s_tvalid_i,
  output logic  s_tready_o,
  input  logic  s_tlast_i,
  input  byte_t s_tdata_i,

  byte_stream_if.source tx
);

  localparam pkt_count_t CMAX = pkt_count_t'(`USB_MAX_PACKET_SIZE - 1);
  localparam int FULL_MARK = `PACKET_FIFO_DEPTH - `USB_MAX_PACKET_SIZE;

  rx_state_t   rx_state;
  tx_state_t   tx_state;
  logic        conf_q;
  logic        par_q;
  logic        full_q;
  logic        zdp_q;
  pkt_count_t  rcount;
  pkt_count_t  scount;
  fifo_level_t level_w;
  byte_t       data_r;

  logic fifo_clr;
  logic fifo_ready;
  logic save_w, redo_w, next_w;
  logic tvalid_r, tready_r, tlast_r;
  logic chunk_end;
  logic tx_fire;

  // FIFO is wiped on the same edge as a configuration event
  assign fifo_clr = rst_i || set_conf_i || clr_conf_i;

  assign stalled_o = !conf_q;
  assign parity_o = par_q;
  assign ep_ready_o = tvalid_r || zdp_q;

  assign s_tready_o = fifo_ready && rx_state == RX_RECV;

  // Chunk closes at frame end or after a full packet of bytes
  assign save_w = s_tvalid_i && s_tready_o && (s_tlast_i || rcount == CMAX);
  assign chunk_end = tlast_r || scount == CMAX;

  assign tx.tvalid = (tx_state == TX_SEND && tvalid_r) || tx_state == TX_NONE;
  assign tx.tkeep = tx_state == TX_SEND;
  assign tx.tlast = (tx_state == TX_SEND && chunk_end) || tx_state == TX_NONE;
  assign tx.tdata = tx.tkeep ? data_r : '0;
  assign tready_r = tx_state == TX_SEND && tx.tready;
  assign tx_fire = tx.tvalid && tx.tready;

  // Host response only counts while the packet is out
  assign redo_w = tx_state == TX_WAIT && selected_i && timedout_i;
  assign next_w = tx_state == TX_WAIT && selected_i && ack_recv_i;

  always_ff @(posedge clock) begin
    if (rst_i || clr_conf_i) begin
      conf_q <= 1'b0;
    end else if (set_conf_i) begin
      conf_q <= 1'b1;
    end
  end

  // Starts at DATA0 after configuration and flips on every ACK including ZDPs
  always_ff @(posedge clock) begin
    if (rst_i || set_conf_i) begin
      par_q <= 1'b0;
    end else if (next_w) begin
      par_q <= !par_q;
    end
  end

  always_ff @(posedge clock) begin
    if (fifo_clr) begin
      rcount <= '0;
      scount <= '0;
    end else begin
      if (s_tvalid_i && s_tready_o) begin
        rcount <= save_w ? '0 : rcount + 1'b1;
      end
      if (tx_state == TX_SEND && tx_fire) begin
        scount <= chunk_end ? '0 : scount + 1'b1;
      end
    end
  end

  // Receive side stops taking bytes while less than a chunk of room is left
  always_ff @(posedge clock) begin
    if (rst_i || clr_conf_i) begin
      rx_state <= RX_HALT;
    end else if (set_conf_i) begin
      rx_state <= RX_RECV;
    end else begin
      case (rx_state)
        RX_RECV: if (save_w && level_w >= fifo_level_t'(FULL_MARK)) rx_state <= RX_FULL;
        // Level only falls on an ACK
        RX_FULL: if (level_w <= fifo_level_t'(FULL_MARK)) rx_state <= RX_RECV;
        default: rx_state <= rx_state;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (fifo_clr || !conf_q) begin
      tx_state <= TX_IDLE;
      full_q <= 1'b0;
      zdp_q <= 1'b0;
    end else begin
      case (tx_state)
        // Owed ZDP goes out before any further data
        TX_IDLE, TX_REDO: begin
          if (selected_i) begin
            tx_state <= zdp_q ? TX_NONE : TX_SEND;
          end
        end
        TX_SEND: begin
          if (tx_fire && chunk_end) begin
            tx_state <= TX_WAIT;
            // Frame ended exactly on a full chunk
            full_q <= tlast_r && scount == CMAX;
          end
        end
        TX_NONE: if (tx_fire) tx_state <= TX_WAIT;
        TX_WAIT: begin
          if (next_w) begin
            tx_state <= TX_IDLE;
            // An acked ZDP clears the debt and an acked data chunk may create one
            zdp_q <= !zdp_q && full_q;
          end else if (redo_w) begin
            tx_state <= TX_REDO;
          end
        end
        default: tx_state <= TX_IDLE;
      endcase
    end
  end

  packet_fifo u_fifo (
    .clock   (clock),
    .rst_i   (fifo_clr),
    .save_i  (save_w),
    .redo_i  (redo_w),
    .next_i  (next_w),
    .valid_i (s_tvalid_i && rx_state == RX_RECV),
    .ready_o (fifo_ready),
    .last_i  (s_tlast_i),
    .data_i  (s_tdata_i),
    .valid_o (tvalid_r),
    .ready_i (tready_r),
    .last_o  (tlast_r),
    .data_o  (data_r),
    .level_o (level_w)
  );

endmodule

// ==== rtl/ep_tx_mux.sv ====
`timescale 1ns/1ns

`include "usb_bulk_config.svh"

module ep_tx_mux
  import usb_bulk_pkg::*;
(
  input  logic     clock,
  input  logic     rst_i,

  // IN token and host response strobes
  input  logic     token_i,
  input  ep_addr_t token_ep_i,
  input  logic     ack_recv_i,
  input  logic     timedout_i,

  // Endpoint status
  input  logic     parity1_i,
  input  logic     parity2_i,
  input  logic     ready1_i,
  input  logic     ready2_i,

  output logic     sel1_o,
  output logic     sel2_o,
  output logic     ack1_o,
  output logic     ack2_o,
  output logic     tmo1_o,
  output logic     tmo2_o,

  byte_stream_if.sink ep1,
  byte_stream_if.sink ep2,

  // Toward the packet encoder
  output logic     m_tvalid_o,
  input  logic     m_tready_i,
  output logic     m_tlast_o,
  output byte_t    m_tdata_o
);

  mux_state_t state;
  // Low picks endpoint 1
  logic       sel_q;
  logic       hit1, hit2;
  logic       fwd;
  logic       cur_valid, cur_keep, cur_last, cur_parity;
  byte_t      cur_data;

  // Tokens to an endpoint with nothing queued are not taken
  assign hit1 = token_i && token_ep_i == `EP1_ADDR && ready1_i;
  assign hit2 = token_i && token_ep_i == `EP2_ADDR && ready2_i;

  always_comb begin
    if (sel_q) begin
      cur_valid = ep2.tvalid;
      cur_keep = ep2.tkeep;
      cur_last = ep2.tlast;
      cur_data = ep2.tdata;
      cur_parity = parity2_i;
    end else begin
      cur_valid = ep1.tvalid;
      cur_keep = ep1.tkeep;
      cur_last = ep1.tlast;
      cur_data = ep1.tdata;
      cur_parity = parity1_i;
    end
  end

  // ZDP beat is swallowed together with the PID
  assign fwd = m_tready_i && (state == MX_DATA || (state == MX_PID && !cur_keep));
  assign ep1.tready = fwd && !sel_q;
  assign ep2.tready = fwd && sel_q;

  assign sel1_o = state != MX_IDLE && !sel_q;
  assign sel2_o = state != MX_IDLE && sel_q;
  assign ack1_o = state == MX_WAIT && !sel_q && ack_recv_i;
  assign ack2_o = state == MX_WAIT && sel_q && ack_recv_i;
  assign tmo1_o = state == MX_WAIT && !sel_q && timedout_i;
  assign tmo2_o = state == MX_WAIT && sel_q && timedout_i;

  always_comb begin
    m_tvalid_o = 1'b0;
    m_tlast_o = 1'b0;
    m_tdata_o = cur_data;
    case (state)
      // PID waits for the endpoint's first beat to know the packet kind
      MX_PID: begin
        m_tvalid_o = cur_valid;
        m_tlast_o = !cur_keep;
        m_tdata_o = cur_parity ? PID_DATA1 : PID_DATA0;
      end
      MX_DATA: begin
        m_tvalid_o = cur_valid;
        m_tlast_o = cur_last;
      end
      default: begin
        m_tvalid_o = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst_i) begin
      state <= MX_IDLE;
      sel_q <= 1'b0;
    end else begin
      case (state)
        MX_IDLE: begin
          if (hit1 || hit2) begin
            state <= MX_PID;
            sel_q <= hit2;
          end
        end
        MX_PID: if (cur_valid && m_tready_i) state <= cur_keep ? MX_DATA : MX_WAIT;
        MX_DATA: if (cur_valid && m_tready_i && cur_last) state <= MX_WAIT;
        MX_WAIT: if (ack_recv_i || timedout_i) state <= MX_IDLE;
        default: state <= MX_IDLE;
      endcase
    end
  end

endmodule

// ==== rtl/usb_bulk_in_top.sv ====
`timescale 1ns/1ns

module usb_bulk_in_top
  import usb_bulk_pkg::*;
(
  input  logic       clock,
  input  logic       rst_i,

  // Per-endpoint configuration events, bit 0 is endpoint 1
  input  logic [1:0] set_conf_i,
  input  logic [1:0] clr_conf_i,

  input  logic       token_i,
  input  ep_addr_t   token_ep_i,
  input  logic       ack_recv_i,
  input  logic       timedout_i,

  input  logic       s1_tvalid_i,
  output logic       s1_tready_o,
  input  logic       s1_tlast_i,
  input  byte_t      s1_tdata_i,

  input  logic       s2_tvalid_i,
  output logic       s2_tready_o,
  input  logic       s2_tlast_i,
  input  byte_t      s2_tdata_i,

  output logic       m_tvalid_o,
  input  logic       m_tready_i,
  output logic       m_tlast_o,
  output byte_t      m_tdata_o,

  output logic [1:0] ep_ready_o,
  output logic [1:0] stalled_o
);

  logic sel1, sel2, ack1, ack2, tmo1, tmo2;
  logic par1, par2;

  byte_stream_if ep1_tx ();
  byte_stream_if ep2_tx ();

  ep_bulk_in u_ep1 (
    .clock      (clock),
    .rst_i      (rst_i),
    .set_conf_i (set_conf_i[0]),
    .clr_conf_i (clr_conf_i[0]),
    .selected_i (sel1),
    .ack_recv_i (ack1),
    .timedout_i (tmo1),
    .ep_ready_o (ep_ready_o[0]),
    .stalled_o  (stalled_o[0]),
    .parity_o   (par1),
    .s_tvalid_i (s1_tvalid_i),
    .s_tready_o (s1_tready_o),
    .s_tlast_i  (s1_tlast_i),
    .s_tdata_i  (s1_tdata_i),
    .tx         (ep1_tx)
  );

  ep_bulk_in u_ep2 (
    .clock      (clock),
    .rst_i      (rst_i),
    .set_conf_i (set_conf_i[1]),
    .clr_conf_i (clr_conf_i[1]),
    .selected_i (sel2),
    .ack_recv_i (ack2),
    .timedout_i (tmo2),
    .ep_ready_o (ep_ready_o[1]),
    .stalled_o  (stalled_o[1]),
    .parity_o   (par2),
    .s_tvalid_i (s2_tvalid_i),
    .s_tready_o (s2_tready_o),
    .s_tlast_i  (s2_tlast_i),
    .s_tdata_i  (s2_tdata_i),
    .tx         (ep2_tx)
  );

  ep_tx_mux u_mux (
    .clock      (clock),
    .rst_i      (rst_i),
    .token_i    (token_i),
    .token_ep_i (token_ep_i),
    .ack_recv_i (ack_recv_i),
    .timedout_i (timedout_i),
    .parity1_i  (par1),
    .parity2_i  (par2),
    .ready1_i   (ep_ready_o[0]),
    .ready2_i   (ep_ready_o[1]),
    .sel1_o     (sel1),
    .sel2_o     (sel2),
    .ack1_o     (ack1),
    .ack2_o     (ack2),
    .tmo1_o     (tmo1),
    .tmo2_o     (tmo2),
    .ep1        (ep1_tx),
    .ep2        (ep2_tx),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i),
    .m_tlast_o  (m_tlast_o),
    .m_tdata_o  (m_tdata_o)
  );

endmodule

// ==== verification/tb_usb_bulk_in_asserts.sv ====
`timescale 1ns/1ns

module tb_usb_bulk_in_asserts
  import usb_bulk_pkg::*;
(
  input logic  clock,
  input logic  rst_i,

  // Encoder side stream
  input logic  m_valid_i,
  input logic  m_ready_i,
  input logic  m_last_i,
  input byte_t m_data_i,

  // Endpoint transmit streams at the multiplexer
  input logic  ep1_valid_i,
  input logic  ep1_keep_i,
  input logic  ep1_last_i,
  input logic  ep2_valid_i,
  input logic  ep2_keep_i,
  input logic  ep2_last_i,

  input logic  sel1_i,
  input logic  sel2_i
);

  // Number of failed checks in this instance
  int fail_count = 0;

  // An offered beat stays put until it is taken
  hold_until_ready: assert property (
    @(posedge clock) disable iff (rst_i)
    m_valid_i && !m_ready_i |=> m_valid_i && $stable(m_data_i) && $stable(m_last_i)
  ) else begin
    fail_count++;
    $error("stream beat dropped or changed before it was taken");
  end

  // Keep low marks the ZDP beat, which is always the last one
  ep1_keep_low_on_last: assert property (
    @(posedge clock) disable iff (rst_i)
    ep1_valid_i && !ep1_keep_i |-> ep1_last_i
  ) else begin
    fail_count++;
    $error("endpoint 1 keep low on a beat that is not the last");
  end

  ep2_keep_low_on_last: assert property (
    @(posedge clock) disable iff (rst_i)
    ep2_valid_i && !ep2_keep_i |-> ep2_last_i
  ) else begin
    fail_count++;
    $error("endpoint 2 keep low on a beat that is not the last");
  end

  // Only one endpoint owns the bus at a time
  single_selection: assert property (
    @(posedge clock) disable iff (rst_i)
    !(sel1_i && sel2_i)
  ) else begin
    fail_count++;
    $error("both endpoints selected at once");
  end

endmodule

// Encoder side stream, both endpoint streams and both select lines
bind ep_tx_mux tb_usb_bulk_in_asserts u_mux_chk (
  .clock       (clock),
  .rst_i       (rst_i),
  .m_valid_i   (m_tvalid_o),
  .m_ready_i   (m_tready_i),
  .m_last_i    (m_tlast_o),
  .m_data_i    (m_tdata_o),
  .ep1_valid_i (ep1.tvalid),
  .ep1_keep_i  (ep1.tkeep),
  .ep1_last_i  (ep1.tlast),
  .ep2_valid_i (ep2.tvalid),
  .ep2_keep_i  (ep2.tkeep),
  .ep2_last_i  (ep2.tlast),
  .sel1_i      (sel1_o),
  .sel2_i      (sel2_o)
);

// ==== verification/tb_usb_bulk_in.sv ====
`timescale 1ns/1ns

`include "usb_bulk_config.svh"

module tb_usb_bulk_in
  import usb_bulk_pkg::*;
();

  // Longest single wait in cycles
  localparam int TIMEOUT = 200;
  localparam int MPS = `USB_MAX_PACKET_SIZE;

  logic       clock;
  logic       rst_i;
  logic [1:0] set_conf_i;
  logic [1:0] clr_conf_i;
  logic       token_i;
  ep_addr_t   token_ep_i;
  logic       ack_recv_i;
  logic       timedout_i;
  logic       s1_tvalid_i;
  logic       s1_tready_o;
  logic       s1_tlast_i;
  byte_t      s1_tdata_i;
  logic       s2_tvalid_i;
  logic       s2_tready_o;
  logic       s2_tlast_i;
  byte_t      s2_tdata_i;
  logic       m_tvalid_o;
  logic       m_tready_i;
  logic       m_tlast_o;
  byte_t      m_tdata_o;
  logic [1:0] ep_ready_o;
  logic [1:0] stalled_o;

  integer seed;
  int     errors;
  int     checks;
  // Random encoder stalls when set
  logic   backpressure;

  // Reference model holding bytes and chunk lengths per endpoint
  byte_t  exp_data1[$];
  byte_t  exp_data2[$];
  int     exp_len1[$];
  int     exp_len2[$];
  // Next DATA toggle per endpoint with bit 0 for endpoint 1
  logic [1:0] toggle;

  usb_bulk_in_top i_dut (.*);

  always #5 clock = ~clock;

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic check(input string name, input logic [31:0] got,
                       input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
    end
  endtask

  task automatic drive_source(input int ep, input logic valid, input logic last,
                              input byte_t data);
    if (ep == 1) begin
      s1_tvalid_i = valid;
      s1_tlast_i = last;
      s1_tdata_i = data;
    end else begin
      s2_tvalid_i = valid;
      s2_tlast_i = last;
      s2_tdata_i = data;
    end
  endtask

  function automatic logic source_ready(input int ep);
    return (ep == 1) ? s1_tready_o : s2_tready_o;
  endfunction

  task automatic issue_token(input ep_addr_t addr);
    token_i = 1'b1;
    token_ep_i = addr;
    next_cycle();
    token_i = 1'b0;
  endtask

  // Encoder stream must stay idle the whole window
  task automatic expect_quiet(input int cycles);
    int busy;
    busy = 0;
    for (int i = 0; i < cycles; i++) begin
      if (m_tvalid_o) begin
        busy++;
      end
      next_cycle();
    end
    check("m_tvalid_o busy cycles", busy, 0);
  endtask

  // Clears the masked endpoints and restarts their toggle at DATA0
  task automatic configure(input logic [1:0] mask);
    set_conf_i = mask;
    next_cycle();
    set_conf_i = 2'b00;
    toggle = toggle & ~mask;
    next_cycle();
    check("stalled_o", stalled_o & mask, 2'b00);
  endtask

  // Random frame into one endpoint with its chunks added to the model
  task automatic send_frame(input int ep, input int len);
    byte_t b;
    int    rest;
    int    wait_cnt;
    // Full chunks first, then the remainder or an empty ZDP chunk
    rest = len;
    while (rest >= MPS) begin
      if (ep == 1) begin
        exp_len1.push_back(MPS);
      end else begin
        exp_len2.push_back(MPS);
      end
      rest -= MPS;
    end
    if (ep == 1) begin
      exp_len1.push_back(rest);
    end else begin
      exp_len2.push_back(rest);
    end
    for (int i = 0; i < len; i++) begin
      b = byte_t'($random(seed));
      if (ep == 1) begin
        exp_data1.push_back(b);
      end else begin
        exp_data2.push_back(b);
      end
      drive_source(ep, 1'b1, i == len - 1, b);
      wait_cnt = 0;
      while (!source_ready(ep) && wait_cnt < TIMEOUT) begin
        next_cycle();
        wait_cnt++;
      end
      if (!source_ready(ep)) begin
        errors++;
        $display("Endpoint %0d did not take frame byte %0d in time", ep, i);
        drive_source(ep, 1'b0, 1'b0, 8'h00);
        return;
      end
      next_cycle();
    end
    drive_source(ep, 1'b0, 1'b0, 8'h00);
  endtask

  // One IN transaction checked against the model and answered with ACK or timeout
  task automatic in_transaction(input int ep, input logic ack);
    byte_t       got[$];
    byte_t       want[$];
    int          len;
    int          wait_cnt;
    logic        seen_last;
    logic        v;
    logic        l;
    byte_t       d;
    logic [31:0] rnd;
    if ((ep == 1 ? exp_len1.size() : exp_len2.size()) == 0) begin
      errors++;
      $display("No packet left in the model for endpoint %0d", ep);
      return;
    end
    len = (ep == 1) ? exp_len1[0] : exp_len2[0];
    for (int i = 0; i < len; i++) begin
      want.push_back(ep == 1 ? exp_data1[i] : exp_data2[i]);
    end
    // Token is only taken once the endpoint offers data
    wait_cnt = 0;
    while (!ep_ready_o[ep-1] && wait_cnt < TIMEOUT) begin
      next_cycle();
      wait_cnt++;
    end
    if (!ep_ready_o[ep-1]) begin
      errors++;
      $display("Endpoint %0d never became ready for a token", ep);
      return;
    end
    issue_token(ep_addr_t'(ep));
    seen_last = 1'b0;
    wait_cnt = 0;
    while (!seen_last && wait_cnt < TIMEOUT) begin
      v = m_tvalid_o;
      l = m_tlast_o;
      d = m_tdata_o;
      rnd = $random(seed);
      m_tready_i = !backpressure || rnd[0];
      if (v && m_tready_i) begin
        got.push_back(d);
        seen_last = l;
      end
      next_cycle();
      wait_cnt++;
    end
    m_tready_i = 1'b1;
    if (!seen_last) begin
      errors++;
      $display("Packet from endpoint %0d never reached its last byte", ep);
      return;
    end
    check("packet byte count", got.size(), len + 1);
    check("m_tdata_o pid", got[0], toggle[ep-1] ? PID_DATA1 : PID_DATA0);
    for (int i = 0; i < len && i + 1 < got.size(); i++) begin
      check($sformatf("m_tdata_o byte %0d", i), got[i+1], want[i]);
    end
    // Host response while the multiplexer waits
    if (ack) begin
      ack_recv_i = 1'b1;
    end else begin
      timedout_i = 1'b1;
    end
    next_cycle();
    ack_recv_i = 1'b0;
    timedout_i = 1'b0;
    if (ack) begin
      toggle[ep-1] = !toggle[ep-1];
      for (int i = 0; i < len; i++) begin
        if (ep == 1) begin
          void'(exp_data1.pop_front());
        end else begin
          void'(exp_data2.pop_front());
        end
      end
      if (ep == 1) begin
        void'(exp_len1.pop_front());
      end else begin
        void'(exp_len2.pop_front());
      end
    end
  endtask

  task automatic unconfigured_stays_idle();
    int ready_seen;
    check("stalled_o", stalled_o, 2'b11);
    check("ep_ready_o", ep_ready_o, 2'b00);
    drive_source(1, 1'b1, 1'b1, 8'h5a);
    drive_source(2, 1'b1, 1'b1, 8'ha5);
    ready_seen = 0;
    for (int i = 0; i < 10; i++) begin
      if (s1_tready_o || s2_tready_o) begin
        ready_seen++;
      end
      next_cycle();
    end
    drive_source(1, 1'b0, 1'b0, 8'h00);
    drive_source(2, 1'b0, 1'b0, 8'h00);
    check("s_tready_o high cycles", ready_seen, 0);
    issue_token(`EP1_ADDR);
    expect_quiet(50);
  endtask

  task automatic short_frame_toggle();
    configure(2'b01);
    send_frame(1, 5);
    in_transaction(1, 1'b1);
    // Second packet must carry DATA1
    send_frame(1, 3);
    in_transaction(1, 1'b1);
  endtask

  task automatic long_frame_chunks();
    send_frame(1, 20);
    repeat (3) in_transaction(1, 1'b1);
  endtask

  task automatic full_frame_zdp();
    send_frame(1, 16);
    repeat (3) in_transaction(1, 1'b1);
  endtask

  task automatic timeout_retry();
    send_frame(1, 12);
    // Same chunk and PID come back after each timeout
    in_transaction(1, 1'b0);
    in_transaction(1, 1'b0);
    in_transaction(1, 1'b1);
    in_transaction(1, 1'b1);
  endtask

  task automatic both_endpoints_mixed();
    configure(2'b10);
    backpressure = 1'b1;
    send_frame(1, 11);
    send_frame(2, 16);
    // Address 3 has no endpoint
    issue_token(4'd3);
    expect_quiet(50);
    in_transaction(1, 1'b1);
    in_transaction(2, 1'b1);
    in_transaction(1, 1'b1);
    in_transaction(2, 1'b0);
    in_transaction(2, 1'b1);
    in_transaction(2, 1'b1);
    backpressure = 1'b0;
    check("endpoint 1 chunks left", exp_len1.size(), 0);
    check("endpoint 2 chunks left", exp_len2.size(), 0);
  endtask

  initial begin
    int assert_fails;
    clock = 1'b0;
    rst_i = 1'b1;
    set_conf_i = 2'b00;
    clr_conf_i = 2'b00;
    token_i = 1'b0;
    token_ep_i = '0;
    ack_recv_i = 1'b0;
    timedout_i = 1'b0;
    drive_source(1, 1'b0, 1'b0, 8'h00);
    drive_source(2, 1'b0, 1'b0, 8'h00);
    m_tready_i = 1'b1;
    seed = 32'h985f;
    errors = 0;
    checks = 0;
    backpressure = 1'b0;
    toggle = 2'b00;
    repeat (5) @(posedge clock);
    #1;
    rst_i = 1'b0;
    next_cycle();
    unconfigured_stays_idle();
    short_frame_toggle();
    long_frame_chunks();
    full_frame_zdp();
    timeout_retry();
    both_endpoints_mixed();
    assert_fails = i_dut.u_mux.u_mux_chk.fail_count;
    if (assert_fails != 0) begin
      errors += assert_fails;
      $display("Bound assertions failed %0d times", assert_fails);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/usb_bulk_pkg.sv
rtl/byte_stream_if.sv
rtl/packet_fifo.sv
rtl/ep_bulk_in.sv
rtl/ep_tx_mux.sv
rtl/usb_bulk_in_top.sv
verification/tb_usb_bulk_in_asserts.sv
verification/tb_usb_bulk_in.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_usb_bulk_in -Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_bin +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
  exit 1
fi
exit 0
